//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/10ps -j 0 --top-module decodeStageTb -f sources.f
	out=$$(./obj_dir/VdecodeStageTb 2>&1); echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

//--- source/branchResolve.sv
// operand forwarding from E and M, branch and conditional move comparison
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module branchResolve (
    input  isaPkg::instrT    instr,
    input  pipePkg::regAddrT rsAddr,
    input  pipePkg::regAddrT rtAddr,
    input  pipePkg::wordT    dataRs,
    input  pipePkg::wordT    dataRt,
    input  logic             regWEnE,
    input  pipePkg::regAddrT regWAddrE,
    input  pipePkg::wordT    regWDataE,
    input  logic             regWEnM,
    input  pipePkg::regAddrT regWAddrM,
    input  pipePkg::wordT    regWDataM,
    output pipePkg::wordT    rsUse,
    output pipePkg::wordT    rtUse,
    output logic             cmp
);
    import isaPkg::*;
    import pipePkg::*;

    // younger producer wins, $0 never forwards
    function automatic wordT forward(input regAddrT addr, input wordT grf);
        if (regWEnE && (regWAddrE == addr) && (regWAddrE != '0))
            return regWDataE;
        else if (regWEnM && (regWAddrM == addr) && (regWAddrM != '0))
            return regWDataM;
        return grf;
    endfunction

    always_comb begin
        rsUse = forward(rsAddr, dataRs);
        rtUse = forward(rtAddr, dataRt);
    end

    always_comb begin
        case (instr)
            BEQ:            cmp = (rsUse == rtUse);
            BNE:            cmp = (rsUse != rtUse);
            BGEZ, BGEZAL:   cmp = !rsUse[`WORD_W-1];
            BLTZ, BLTZAL:   cmp = rsUse[`WORD_W-1];
            BGTZ:           cmp = !rsUse[`WORD_W-1] && (rsUse != '0);
            BLEZ:           cmp = rsUse[`WORD_W-1] || (rsUse == '0);
            MOVZ:           cmp = (rtUse == '0);
            MOVN:           cmp = (rtUse != '0);
            default:        cmp = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decodeStage.sv
// MIPS decode stage with forwarding, branch compare and the D/E pipeline register
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             clear,
    input  pipePkg::wordT    code,
    input  pipePkg::wordT    pc,
    input  pipePkg::wordT    dataRs,
    input  pipePkg::wordT    dataRt,
    input  logic             regWEnM,
    input  pipePkg::regAddrT regWAddrM,
    input  pipePkg::wordT    regWDataM,
    output isaPkg::instrT    instrD,
    output pipePkg::regAddrT rsAddrD,
    output pipePkg::regAddrT rtAddrD,
    output pipePkg::tcountT  tuseRsD,
    output pipePkg::tcountT  tuseRtD,
    output pipePkg::tcountT  tnewD,
    output logic             cmpD,
    output isaPkg::jaddrT    jumpAddrD,
    output pipePkg::wordT    jumpRegD,
    output isaPkg::instrT    instrE,
    output isaPkg::groupT    groupE,
    output pipePkg::wordT    pcE,
    output logic             reservedE,
    output pipePkg::regAddrT rsAddrE,
    output pipePkg::regAddrT rtAddrE,
    output pipePkg::regAddrT rdAddrE,
    output pipePkg::wordT    dataRsE,
    output pipePkg::wordT    dataRtE,
    output pipePkg::wordT    extImmE,
    output pipePkg::wordT    extShamtE,
    output logic             regWEnE,
    output pipePkg::regAddrT regWAddrE,
    output pipePkg::wordT    regWDataE,
    output logic             regWValidE,
    output pipePkg::tcountT  tnewE
);
    import isaPkg::*;
    import pipePkg::*;

    groupT   groupD;
    logic    reservedD;
    regAddrT rdAddrD;
    shamtT   shamtD;
    immT     immD;
    wordT    rsUseD;
    wordT    extImmD;
    wordT    extShamtD;
    logic    regWEnD;
    regAddrT regWAddrD;
    wordT    regWDataD;
    logic    regWValidD;
    tcountT  tnewNext;

    instrDecoder u_decoder (
        .code(code), .rsAddr(rsAddrD), .rtAddr(rtAddrD), .rdAddr(rdAddrD),
        .shamt(shamtD), .imm(immD), .jumpAddr(jumpAddrD), .instr(instrD),
        .group(groupD), .reserved(reservedD),
        .tuseRs(tuseRsD), .tuseRt(tuseRtD), .tnew(tnewD)
    );

    // E-stage write comes straight from our own register
    branchResolve u_resolve (
        .instr(instrD), .rsAddr(rsAddrD), .rtAddr(rtAddrD),
        .dataRs(dataRs), .dataRt(dataRt),
        .regWEnE(regWEnE), .regWAddrE(regWAddrE), .regWDataE(regWDataE),
        .regWEnM(regWEnM), .regWAddrM(regWAddrM), .regWDataM(regWDataM),
        .rsUse(rsUseD), .rtUse(), .cmp(cmpD)
    );

    writePlan u_plan (
        .instr(instrD), .group(groupD), .imm(immD), .shamt(shamtD),
        .rtAddr(rtAddrD), .rdAddr(rdAddrD), .cmp(cmpD), .rsUse(rsUseD), .pc(pc),
        .extImm(extImmD), .extShamt(extShamtD), .regWEn(regWEnD),
        .regWAddr(regWAddrD), .regWData(regWDataD), .regWValid(regWValidD)
    );

    assign jumpRegD = rsUseD;

    // one cycle spent in D, saturate at zero
    assign tnewNext = (tnewD != '0) ? tcountT'(tnewD - 1'b1) : '0;

    // stall holds and wins over clear
    always_ff @(posedge clk) begin
        if (reset || (clear && !stall)) begin
            instrE     <= NOP;
            groupE     <= OTHER;
            pcE        <= '0;
            reservedE  <= 1'b0;
            rsAddrE    <= '0;
            rtAddrE    <= '0;
            rdAddrE    <= '0;
            dataRsE    <= '0;
            dataRtE    <= '0;
            extImmE    <= '0;
            extShamtE  <= '0;
            regWEnE    <= 1'b0;
            regWAddrE  <= '0;
            regWDataE  <= '0;
            regWValidE <= 1'b0;
            tnewE      <= '0;
        end else if (!stall) begin
            instrE     <= instrD;
            groupE     <= groupD;
            pcE        <= pc;
            reservedE  <= reservedD;
            rsAddrE    <= rsAddrD;
            rtAddrE    <= rtAddrD;
            rdAddrE    <= rdAddrD;
            // E re-forwards on its own, keep raw GRF values
            dataRsE    <= dataRs;
            dataRtE    <= dataRt;
            extImmE    <= extImmD;
            extShamtE  <= extShamtD;
            regWEnE    <= regWEnD;
            regWAddrE  <= regWAddrD;
            regWDataE  <= regWDataD;
            regWValidE <= regWValidD;
            tnewE      <= tnewNext;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_defs.svh
// decode stage widths and fixed constants
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define IMM_W       16
`define JADDR_W     26
`define SHAMT_W     5

// hazard timing
`define T_W         3
`define TUSE_INF    7

// link register and return address
`define LINK_REG    31
`define LINK_OFFSET 8

`endif

//--- source/instrDecoder.sv
// instruction decoder: field split, symbol and group lookup, reserved flag, Tuse and Tnew
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module instrDecoder (
    input  pipePkg::wordT    code,
    output pipePkg::regAddrT rsAddr,
    output pipePkg::regAddrT rtAddr,
    output pipePkg::regAddrT rdAddr,
    output isaPkg::shamtT    shamt,
    output isaPkg::immT      imm,
    output isaPkg::jaddrT    jumpAddr,
    output isaPkg::instrT    instr,
    output isaPkg::groupT    group,
    output logic             reserved,
    output pipePkg::tcountT  tuseRs,
    output pipePkg::tcountT  tuseRt,
    output pipePkg::tcountT  tnew
);
    import isaPkg::*;
    import pipePkg::*;

    localparam tcountT TInf = tcountT'(`TUSE_INF);

    opcodeT opcode;
    functT  funct;
    instrT  rType;
    instrT  regimm;
    instrT  opType;

    assign opcode   = code[31:26];
    assign rsAddr   = code[25:21];
    assign rtAddr   = code[20:16];
    assign rdAddr   = code[15:11];
    assign shamt    = code[10:6];
    assign funct    = code[5:0];
    assign imm      = code[`IMM_W-1:0];
    assign jumpAddr = code[`JADDR_W-1:0];

    // special opcode, keyed by funct
    always_comb begin
        case (funct)
            6'b100000: rType = ADD;
            6'b100010: rType = SUB;
            6'b100001: rType = ADDU;
            6'b100011: rType = SUBU;
            6'b100100: rType = AND;
            6'b100101: rType = OR;
            6'b100110: rType = XOR;
            6'b100111: rType = NOR;
            6'b101010: rType = SLT;
            6'b101011: rType = SLTU;
            6'b000000: rType = SLL;
            6'b000010: rType = SRL;
            6'b000011: rType = SRA;
            6'b000100: rType = SLLV;
            6'b000110: rType = SRLV;
            6'b000111: rType = SRAV;
            6'b001000: rType = JR;
            6'b001001: rType = JALR;
            6'b001010: rType = MOVZ;
            6'b001011: rType = MOVN;
            default:   rType = NOP;
        endcase
    end

    // regimm branches pick the condition through rt
    always_comb begin
        case (rtAddr)
            5'b00000: regimm = BLTZ;
            5'b00001: regimm = BGEZ;
            5'b10000: regimm = BLTZAL;
            5'b10001: regimm = BGEZAL;
            default:  regimm = NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            6'b001000: opType = ADDI;
            6'b001001: opType = ADDIU;
            6'b001100: opType = ANDI;
            6'b001101: opType = ORI;
            6'b001110: opType = XORI;
            6'b001111: opType = LUI;
            6'b001010: opType = SLTI;
            6'b001011: opType = SLTIU;
            6'b100011: opType = LW;
            6'b100001: opType = LH;
            6'b100101: opType = LHU;
            6'b100000: opType = LB;
            6'b100100: opType = LBU;
            6'b101011: opType = SW;
            6'b101001: opType = SH;
            6'b101000: opType = SB;
            6'b000100: opType = BEQ;
            6'b000101: opType = BNE;
            6'b000110: opType = BLEZ;
            6'b000111: opType = BGTZ;
            6'b000010: opType = J;
            6'b000011: opType = JAL;
            default:   opType = NOP;
        endcase
    end

    // all-zero word is the canonical nop, not sll
    always_comb begin
        if (code == '0)
            instr = NOP;
        else if (opcode == 6'b000000)
            instr = rType;
        else if (opcode == 6'b000001)
            instr = regimm;
        else
            instr = opType;
    end

    assign reserved = (code != '0) && (instr == NOP);

    always_comb begin
        case (instr)
            ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SRL, SRA, SLLV, SRLV, SRAV:               group = ALU_R;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU: group = ALU_I;
            LW, LH, LHU, LB, LBU:                          group = MEM_R;
            SW, SH, SB:                                    group = MEM_W;
            BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL: group = BRANCH;
            J, JAL, JR, JALR:                              group = JUMP;
            default:                                       group = OTHER;
        endcase
    end

    // hazard timing, nop and unknown words use nothing and produce nothing
    always_comb begin
        tuseRs = TInf;
        tuseRt = TInf;
        tnew   = '0;
        if (instr == MOVZ || instr == MOVN) begin
            tuseRs = 3'd0;
            tuseRt = 3'd0;
            tnew   = 3'd1;
        end else begin
            case (group)
                ALU_R: begin
                    tuseRs = (instr == SLL || instr == SRL || instr == SRA) ? TInf : 3'd1;
                    tuseRt = 3'd1;
                    tnew   = 3'd2;
                end
                ALU_I: begin
                    tuseRs = (instr == LUI) ? TInf : 3'd1;
                    tnew   = (instr == LUI) ? 3'd1 : 3'd2;
                end
                MEM_R: begin
                    tuseRs = 3'd1;
                    tnew   = (instr == LW) ? 3'd3 : 3'd5;
                end
                MEM_W: begin
                    tuseRs = 3'd1;
                    tuseRt = 3'd2;
                end
                BRANCH: begin
                    tuseRs = 3'd0;
                    tuseRt = (instr == BEQ || instr == BNE) ? 3'd0 : TInf;
                end
                JUMP: begin
                    tuseRs = (instr == JR || instr == JALR) ? 3'd0 : TInf;
                    tnew   = (instr == JAL || instr == JALR) ? 3'd1 : 3'd0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/isaPkg.sv
// MIPS instruction encoding types: symbols, function groups and field vectors
`default_nettype none
`include "decode_defs.svh"

package isaPkg;

    // fixed codes, the golden vectors rely on them
    typedef enum logic [5:0] {
        NOP    = 6'd0,  ADD    = 6'd1,  SUB    = 6'd2,  ADDU   = 6'd3,
        SUBU   = 6'd4,  AND    = 6'd5,  OR     = 6'd6,  XOR    = 6'd7,
        NOR    = 6'd8,  SLT    = 6'd9,  SLTU   = 6'd10, SLL    = 6'd11,
        SRL    = 6'd12, SRA    = 6'd13, SLLV   = 6'd14, SRLV   = 6'd15,
        SRAV   = 6'd16, ADDI   = 6'd17, ADDIU  = 6'd18, ANDI   = 6'd19,
        ORI    = 6'd20, XORI   = 6'd21, LUI    = 6'd22, SLTI   = 6'd23,
        SLTIU  = 6'd24, LW     = 6'd25, LH     = 6'd26, LHU    = 6'd27,
        LB     = 6'd28, LBU    = 6'd29, SW     = 6'd30, SH     = 6'd31,
        SB     = 6'd32, BEQ    = 6'd33, BNE    = 6'd34, BLEZ   = 6'd35,
        BGTZ   = 6'd36, BGEZ   = 6'd37, BLTZ   = 6'd38, BGEZAL = 6'd39,
        BLTZAL = 6'd40, J      = 6'd41, JAL    = 6'd42, JR     = 6'd43,
        JALR   = 6'd44, MOVZ   = 6'd45, MOVN   = 6'd46
    } instrT;

    // OTHER is zero so that a bubble decodes as NOP in OTHER
    typedef enum logic [2:0] {
        OTHER  = 3'd0,
        ALU_R  = 3'd1,
        ALU_I  = 3'd2,
        MEM_R  = 3'd3,
        MEM_W  = 3'd4,
        BRANCH = 3'd5,
        JUMP   = 3'd6
    } groupT;

    // raw instruction fields
    typedef logic [5:0]             opcodeT;
    typedef logic [5:0]             functT;
    typedef logic [`IMM_W-1:0]      immT;
    typedef logic [`JADDR_W-1:0]    jaddrT;
    typedef logic [`SHAMT_W-1:0]    shamtT;

endpackage

`default_nettype wire

//--- source/pipePkg.sv
// pipeline data types: data word, register index and hazard time
`default_nettype none
`include "decode_defs.svh"

package pipePkg;

    // register file data and pc
    typedef logic [`WORD_W-1:0]     wordT;

    // GRF index, 0 is the hardwired zero register
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // Tuse / Tnew in cycles, all ones means never used
    typedef logic [`T_W-1:0]        tcountT;

endpackage

`default_nettype wire

//--- source/writePlan.sv
// immediate extension and register write plan for the decoded instruction
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module writePlan (
    input  isaPkg::instrT    instr,
    input  isaPkg::groupT    group,
    input  isaPkg::immT      imm,
    input  isaPkg::shamtT    shamt,
    input  pipePkg::regAddrT rtAddr,
    input  pipePkg::regAddrT rdAddr,
    input  logic             cmp,
    input  pipePkg::wordT    rsUse,
    input  pipePkg::wordT    pc,
    output pipePkg::wordT    extImm,
    output pipePkg::wordT    extShamt,
    output logic             regWEn,
    output pipePkg::regAddrT regWAddr,
    output pipePkg::wordT    regWData,
    output logic             regWValid
);
    import isaPkg::*;
    import pipePkg::*;

    localparam regAddrT LinkReg = regAddrT'(`LINK_REG);

    wordT signExt;
    wordT zeroExt;
    wordT luiExt;
    logic isLink;

    assign signExt  = {{(`WORD_W - `IMM_W){imm[`IMM_W-1]}}, imm};
    assign zeroExt  = {{(`WORD_W - `IMM_W){1'b0}}, imm};
    assign luiExt   = {imm, {(`WORD_W - `IMM_W){1'b0}}};
    assign extShamt = {{(`WORD_W - `SHAMT_W){1'b0}}, shamt};

    // logical immediates zero-extend
    always_comb begin
        case (instr)
            LUI:            extImm = luiExt;
            ANDI, ORI, XORI: extImm = zeroExt;
            default:        extImm = signExt;
        endcase
    end

    assign isLink = (instr == JAL) || (instr == JALR) || (instr == BGEZAL) || (instr == BLTZAL);

    always_comb begin
        regWEn   = 1'b0;
        regWAddr = '0;
        if (instr == BGEZAL || instr == BLTZAL) begin
            // link only when taken
            regWEn   = cmp;
            regWAddr = cmp ? LinkReg : '0;
        end else if (instr == MOVZ || instr == MOVN) begin
            regWEn   = cmp;
            regWAddr = cmp ? rdAddr : '0;
        end else if (instr == JAL) begin
            regWEn   = 1'b1;
            regWAddr = LinkReg;
        end else if (group == ALU_R || instr == JALR) begin
            regWEn   = 1'b1;
            regWAddr = rdAddr;
        end else if (group == ALU_I || group == MEM_R) begin
            regWEn   = 1'b1;
            regWAddr = rtAddr;
        end
    end

    // data already known in D, ready for forwarding from E
    assign regWData  = (instr == MOVZ || instr == MOVN) ? rsUse :
                       isLink                           ? pc + `LINK_OFFSET :
                       (instr == LUI)                   ? luiExt :
                                                          '0;
    assign regWValid = (instr == JAL) || (instr == LUI) || (instr == MOVZ) || (instr == MOVN);

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/branchResolve.sv
source/writePlan.sv
source/decodeStage.sv
tests/decodeStage_sva.sv
tests/decodeStageTb.sv

//--- tests/decodeStageTb.sv
// decode stage testbench, replays golden vectors and checks the D and E outputs
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module decodeStageTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int ClkPeriod    = 20;
    localparam int NumVec       = 31;
    localparam int VecWords     = 11;
    localparam int Seed         = 24653;

    logic    clk;
    logic    reset;
    logic    stall;
    logic    clear;
    wordT    code;
    wordT    pc;
    wordT    dataRs;
    wordT    dataRt;
    logic    regWEnM;
    regAddrT regWAddrM;
    wordT    regWDataM;
    instrT   instrD;
    regAddrT rsAddrD;
    regAddrT rtAddrD;
    tcountT  tuseRsD;
    tcountT  tuseRtD;
    tcountT  tnewD;
    logic    cmpD;
    jaddrT   jumpAddrD;
    wordT    jumpRegD;
    instrT   instrE;
    groupT   groupE;
    wordT    pcE;
    logic    reservedE;
    regAddrT rsAddrE;
    regAddrT rtAddrE;
    regAddrT rdAddrE;
    wordT    dataRsE;
    wordT    dataRtE;
    wordT    extImmE;
    wordT    extShamtE;
    logic    regWEnE;
    regAddrT regWAddrE;
    wordT    regWDataE;
    logic    regWValidE;
    tcountT  tnewE;

    // eleven words per vector, see the file header for the columns
    wordT golden [0:NumVec*VecWords-1];

    // expected E fields that the vector file does not carry
    wordT    pcModel;
    regAddrT rsModel;
    regAddrT rtModel;
    regAddrT rdModel;
    wordT    dataRsModel;
    wordT    dataRtModel;
    wordT    shamtModel;

    decodeStage u_dut (.*);

    bind decodeStage decodeStage_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod/2) clk = ~clk;
    end

    // worst case is one vector cycle plus a two cycle gap
    initial begin
        #(ClkPeriod * (NumVec * 4 + 100));
        $display("watchdog expired, the simulation timed out");
        stopRun();
    end

    task automatic stopRun();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkInstr(input string name, input instrT got, input instrT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkGroup(input string name, input groupT got, input groupT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkTarget(input string name, input jaddrT got, input jaddrT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkTime(input string name, input tcountT got, input tcountT exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic applyVector(input int v);
        wordT ctl;
        ctl       = golden[v*VecWords];
        reset     = ctl[3];
        stall     = ctl[2];
        clear     = ctl[1];
        regWEnM   = ctl[0];
        regWAddrM = ctl[12:8];
        code      = golden[v*VecWords + 1];
        pc        = golden[v*VecWords + 2];
        dataRs    = golden[v*VecWords + 3];
        dataRt    = golden[v*VecWords + 4];
        regWDataM = golden[v*VecWords + 5];
    endtask

    // reset and clear zero the register, stall holds it
    task automatic updateModel();
        if (reset || (clear && !stall)) begin
            pcModel     = '0;
            rsModel     = '0;
            rtModel     = '0;
            rdModel     = '0;
            dataRsModel = '0;
            dataRtModel = '0;
            shamtModel  = '0;
        end else if (!stall) begin
            pcModel     = pc;
            rsModel     = code[25:21];
            rtModel     = code[20:16];
            rdModel     = code[15:11];
            dataRsModel = dataRs;
            dataRtModel = dataRt;
            shamtModel  = wordT'(code[10:6]);
        end
    endtask

    // same-cycle decode results
    task automatic checkDecode(input int v);
        wordT info;
        info = golden[v*VecWords + 6];
        checkInstr("instrD", instrD, instrT'(info[21:16]));
        checkAddr("rsAddrD", rsAddrD, code[25:21]);
        checkAddr("rtAddrD", rtAddrD, code[20:16]);
        checkTarget("jumpAddrD", jumpAddrD, code[`JADDR_W-1:0]);
        checkTime("tuseRsD", tuseRsD, info[14:12]);
        checkTime("tuseRtD", tuseRtD, info[10:8]);
        checkTime("tnewD", tnewD, info[6:4]);
        checkBit("cmpD", cmpD, info[0]);
        checkWord("jumpRegD", jumpRegD, golden[v*VecWords + 7]);
    endtask

    // pipeline register contents one edge later
    task automatic checkExec(input int v);
        wordT info;
        info = golden[v*VecWords + 8];
        checkInstr("instrE", instrE, instrT'(info[29:24]));
        checkBit("reservedE", reservedE, info[23]);
        checkGroup("groupE", groupE, groupT'(info[22:20]));
        checkBit("regWEnE", regWEnE, info[16]);
        checkAddr("regWAddrE", regWAddrE, info[12:8]);
        checkBit("regWValidE", regWValidE, info[4]);
        checkTime("tnewE", tnewE, info[2:0]);
        checkWord("regWDataE", regWDataE, golden[v*VecWords + 9]);
        checkWord("extImmE", extImmE, golden[v*VecWords + 10]);
        checkWord("pcE", pcE, pcModel);
        checkAddr("rsAddrE", rsAddrE, rsModel);
        checkAddr("rtAddrE", rtAddrE, rtModel);
        checkAddr("rdAddrE", rdAddrE, rdModel);
        checkWord("dataRsE", dataRsE, dataRsModel);
        checkWord("dataRtE", dataRtE, dataRtModel);
        checkWord("extShamtE", extShamtE, shamtModel);
    endtask

    initial begin
        int gap;
        reset       = 1'b1;
        stall       = 1'b0;
        clear       = 1'b0;
        code        = '0;
        pc          = '0;
        dataRs      = '0;
        dataRt      = '0;
        regWEnM     = 1'b0;
        regWAddrM   = '0;
        regWDataM   = '0;
        pcModel     = '0;
        rsModel     = '0;
        rtModel     = '0;
        rdModel     = '0;
        dataRsModel = '0;
        dataRtModel = '0;
        shamtModel  = '0;
        void'($urandom(Seed));
        $readmemh("tests/decode_golden.hex", golden);
        repeat (2) @(posedge clk);
        #2;
        for (int v = 0; v < NumVec; v++) begin
            applyVector(v);
            @(negedge clk);
            checkDecode(v);
            updateModel();
            @(posedge clk);
            #1;
            checkExec(v);
            #1;
            // idle gap under stall keeps E, and so the forwarding source, intact
            gap = $urandom % 3;
            if (gap != 0) begin
                reset = 1'b0;
                clear = 1'b0;
                stall = 1'b1;
                repeat (gap) @(posedge clk);
                #2;
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/decodeStage_sva.sv
// bound checks on the D/E pipeline register: reset, stall hold and clear bubble
`timescale 1ns/10ps
`default_nettype none

module decodeStage_sva (
    input logic             clk,
    input logic             reset,
    input logic             stall,
    input logic             clear,
    input isaPkg::instrT    instrE,
    input isaPkg::groupT    groupE,
    input pipePkg::wordT    pcE,
    input logic             reservedE,
    input pipePkg::regAddrT rsAddrE,
    input pipePkg::regAddrT rtAddrE,
    input pipePkg::regAddrT rdAddrE,
    input pipePkg::wordT    dataRsE,
    input pipePkg::wordT    dataRtE,
    input pipePkg::wordT    extImmE,
    input pipePkg::wordT    extShamtE,
    input logic             regWEnE,
    input pipePkg::regAddrT regWAddrE,
    input pipePkg::wordT    regWDataE,
    input logic             regWValidE,
    input pipePkg::tcountT  tnewE
);
    import isaPkg::*;

    resetZero: assert property (@(posedge clk) reset |=> !regWEnE)
        else $error("regWEnE high in the cycle after reset");

    // reset still wins over a stall
    stallHold: assert property (@(posedge clk) (stall && !reset) |=>
        $stable({instrE, groupE, pcE, reservedE, rsAddrE, rtAddrE, rdAddrE, dataRsE,
                 dataRtE, extImmE, extShamtE, regWEnE, regWAddrE, regWDataE,
                 regWValidE, tnewE}))
        else $error("E register changed while stalled");

    clearBubble: assert property (@(posedge clk) (clear && !stall) |=>
        (instrE == NOP && !regWEnE))
        else $error("clear did not load a bubble");

endmodule

`default_nettype wire

//--- tests/decode_golden.hex
// ctl(mAddr,reset,stall,clear,wenM) code pc dataRs dataRt mData dInfo(instr,tuseRs,tuseRt,tnew,cmp)
// jumpRegD eInfo(instr,reserved|group,wen,waddr,valid,tnew) regWDataE extImmE
000 3C051234 00400000 00000000 00000000 00000000 167710 00000000 16210510 12340000 12340000
501 00A00008 00400004 55555555 00000000 AAAA0000 2B0700 12340000 2B600000 00000000 00000008
501 00A00008 00400008 55555555 00000000 AAAA0000 2B0700 AAAA0000 2B600000 00000000 00000008
001 00000008 0040000C 00000000 00000000 DEADBEEF 2B0700 00000000 2B600000 00000000 00000008
201 10220004 00400010 00000077 00000077 00000078 210000 00000077 21500000 00000000 00000004
000 10220004 00400014 00000077 00000077 00000000 210001 00000077 21500000 00000000 00000004
000 14220008 00400018 00000001 00000002 00000000 220001 00000001 22500000 00000000 00000008
000 1C80FFFC 0040001C 80000000 00000000 00000000 240700 80000000 24500000 00000000 FFFFFFFC
000 18800010 00400020 00000000 00000000 00000000 230701 00000000 23500000 00000000 00000010
000 04910020 00400024 00000005 00000000 00000000 270701 00000005 27511F00 0040002C 00000020
000 04900020 00400028 00000005 00000000 00000000 280700 00000005 28500000 00400030 00000020
000 04800020 0040002C FFFFFFFF 00000000 00000000 260701 FFFFFFFF 26500000 00000000 00000020
000 00E8300A 00400030 00000099 00000000 00000000 2D0011 00000099 2D010610 00000099 0000300A
000 0146480B 00400034 00000042 00000000 00000000 2E0011 00000042 2E010910 00000042 0000480B
000 0C100040 00400038 00000000 00000000 00000000 2A7710 00000000 2A611F10 00400040 00000040
000 03E01009 0040003C 11111111 00000000 00000000 2C0710 00400040 2C610200 00400044 00001009
000 8C48FFFC 00400040 00000000 00000000 00000000 191730 00400044 19310802 00000000 FFFFFFFC
000 90290003 00400044 00001000 00000000 00000000 1D1750 00001000 1D310904 00000000 00000003
000 AC290008 00400048 00001000 00000000 00000000 1E1200 00001000 1E400000 00000000 00000008
000 30838001 0040004C 00000000 00000000 00000000 131720 00000000 13210301 00000000 00008001
004 2063FFFF 00400050 00000033 00000000 00000000 111720 00000000 13210301 00000000 00008001
000 2063FFFF 00400050 00000033 00000000 00000000 111720 00000000 11210301 00000000 FFFFFFFF
006 000520C0 00400054 00000000 00000000 00000000 0B7120 00000000 11210301 00000000 FFFFFFFF
002 000520C0 00400054 00000000 00000000 00000000 0B7120 00000000 00000000 00000000 00000000
000 000520C0 00400058 00000000 00000000 00000000 0B7120 00000000 0B110401 00000000 000020C0
000 71093002 0040005C 00000000 00000000 00000000 007700 00000000 00800000 00000000 00003002
000 00850018 00400060 00000004 00000000 00000000 007700 00000004 00800000 00000000 00000018
000 00000000 00400064 00000000 00000000 00000000 007700 00000000 00000000 00000000 00000000
000 08100010 00400068 00000000 00000000 00000000 297700 00000000 29600000 00000000 00000010
008 00221821 0040006C 00000011 00000022 00000000 031120 00000011 00000000 00000000 00000000
000 00221821 00400070 00000011 00000022 00000000 031120 00000011 03110301 00000000 00001821
